//--- run.sh
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator, runs it and scans the log for failure
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

{ verilator --binary --timing --assert \
    --top-module tb_cga_datapath \
    -f sources.f \
    -o tb_sim \
  && ./obj_dir/tb_sim; } > "$LOG" 2>&1 \
  || echo "Test failed" >> "$LOG"

cat "$LOG"

grep -q "Test failed" "$LOG" \
  && { echo "Simulation FAILED, see $LOG"; exit 1; } \
  || echo "Simulation passed"

//--- sources.f
verilog/wrf_pkg.sv
verilog/alu_pkg.sv
verilog/cga_alu.sv
verilog/cga_wrf_rblock.sv
verilog/cga_wrf.sv
verilog/cga_datapath.sv
test/cga_datapath_props.sv
test/cga_datapath_checker.sv
test/tb_cga_datapath.sv

//--- test/cga_datapath_checker.sv
// Scoreboard for the datapath, keeps a register model and compares DUT outputs every cycle
`default_nettype none

module cga_datapath_checker #(
  parameter int DATA_W = 16
) (
  input  wire                          aluclk,
  input  wire                          rst_n,
  input  wire                          bdest,
  input  wire                          xfetch_n,
  input  wire [wrf_pkg::ADDR_W-1:0]    laa,
  input  wire [wrf_pkg::ADDR_W-1:0]    lba,
  input  wire alu_pkg::alu_op_e        alu_op,
  input  wire [DATA_W-1:0]             lit,
  input  wire [DATA_W-1:0]             a,
  input  wire [DATA_W-1:0]             b,
  input  wire [DATA_W-1:0]             rb,
  input  wire [DATA_W-1:0]             pr,
  input  wire [DATA_W-1:0]             br,
  input  wire [DATA_W-1:0]             xr,
  input  wire [wrf_pkg::NUM_REGS-1:0]  ea,
  input  wire                          wpn,
  input  wire                          wr3,
  input  wire                          wr7,
  // Running totals for the closing line
  output int                           error_count,
  output int                           check_count
);

  // Model of the register file, entry 0 is Z and never written
  logic [DATA_W-1:0] shadow_regs [wrf_pkg::NUM_REGS];
  int errors = 0;
  int checks = 0;

  assign error_count = errors;
  assign check_count = checks;

  // Expected write-back value straight from the opcode definitions
  function automatic logic [DATA_W-1:0] expected_result(
    input alu_pkg::alu_op_e   op,
    input logic [DATA_W-1:0]  x,
    input logic [DATA_W-1:0]  y,
    input logic [DATA_W-1:0]  l
  );
    case (op)
      alu_pkg::OP_PASS_A: return x;
      alu_pkg::OP_PASS_B: return y;
      alu_pkg::OP_ADD:    return x + y;
      alu_pkg::OP_SUB:    return x - y;
      alu_pkg::OP_AND:    return x & y;
      alu_pkg::OP_OR:     return x | y;
      alu_pkg::OP_XOR:    return x ^ y;
      alu_pkg::OP_LIT:    return l;
      default:            return '0;
    endcase
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Compare on the pre-edge values, then advance the model
  always @(posedge aluclk) begin
    logic [DATA_W-1:0]           exp_a;
    logic [DATA_W-1:0]           exp_b;
    logic [DATA_W-1:0]           exp_rb;
    logic [wrf_pkg::NUM_REGS-1:0] exp_ea;
    logic                        p_written;
    if (!rst_n) begin
      for (int i = 0; i < wrf_pkg::NUM_REGS; i++) begin
        shadow_regs[i] = '0;
      end
    end else begin
      exp_a = shadow_regs[laa];
      exp_b = shadow_regs[lba];
      exp_rb = expected_result(alu_op, exp_a, exp_b, lit);
      exp_ea = {{(wrf_pkg::NUM_REGS-1){1'b0}}, 1'b1} << laa;
      p_written = bdest && (lba == wrf_pkg::REG_P);
      compare_field("a", 32'(a), 32'(exp_a));
      compare_field("b", 32'(b), 32'(exp_b));
      compare_field("rb", 32'(rb), 32'(exp_rb));
      compare_field("pr", 32'(pr), 32'(shadow_regs[wrf_pkg::REG_P]));
      compare_field("br", 32'(br), 32'(shadow_regs[wrf_pkg::REG_B]));
      compare_field("xr", 32'(xr), 32'(shadow_regs[wrf_pkg::REG_X]));
      compare_field("ea", 32'(ea), 32'(exp_ea));
      // Strobes from bdest and lba only
      compare_field("wpn", 32'(wpn), 32'(!p_written));
      compare_field("wr3", 32'(wr3), 32'(bdest && (lba == wrf_pkg::REG_B)));
      compare_field("wr7", 32'(wr7), 32'(bdest && (lba == wrf_pkg::REG_X)));
      // Z swallows writes
      if (bdest && (lba != wrf_pkg::REG_Z)) begin
        shadow_regs[lba] = exp_rb;
      end
      // Fetch loses to a P write in the same step
      if (!xfetch_n && !p_written) begin
        shadow_regs[wrf_pkg::REG_P] = shadow_regs[wrf_pkg::REG_P] + DATA_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- test/cga_datapath_props.sv
// Strobe and enable assertions bound into every cga_wrf instance by the bind below
`default_nettype none

module cga_datapath_props (
  input wire                         aluclk,
  input wire                         rst_n,
  input wire                         bdest,
  input wire [wrf_pkg::NUM_REGS-1:0] ea,
  input wire [wrf_pkg::NUM_REGS-1:0] wr,
  input wire                         wpn,
  input wire                         wr3,
  input wire                         wr7
);

  // Source decode always selects exactly one register
  ea_onehot: assert property (@(posedge aluclk) disable iff (!rst_n) $onehot(ea))
    else $error("Source enable ea is not one-hot: %h", ea);

  // At most one destination per step
  wr_onehot0: assert property (@(posedge aluclk) disable iff (!rst_n) $onehot0(wr))
    else $error("More than one write strobe active: %h", wr);

  // Nothing written in an idle step
  idle_no_strobe: assert property (@(posedge aluclk) disable iff (!rst_n)
    !bdest |-> (wr == '0) && wpn && !wr3 && !wr7)
    else $error("Write strobe active while bdest is low");

endmodule

bind cga_wrf cga_datapath_props props (
  .aluclk(aluclk),
  .rst_n (rst_n),
  .bdest (bdest),
  .ea    (ea),
  .wr    (wr),
  .wpn   (wpn),
  .wr3   (wr3),
  .wr7   (wr7)
);

`default_nettype wire

//--- test/tb_cga_datapath.sv
// Testbench top for the datapath, runs directed and random microsteps and reports the verdict
`default_nettype none

module tb_cga_datapath;

  localparam int DATA_W       = 16;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int RAND_STEPS   = 400;
  localparam int FETCH_STEPS  = 6;
  // Reset, three register sweeps, random run, fetch run and a short tail
  localparam int TOTAL_STEPS  = RESET_CYCLES + 3 * wrf_pkg::NUM_REGS + RAND_STEPS
                                + FETCH_STEPS + 8;
  localparam int WATCHDOG_TIME = (TOTAL_STEPS + 20) * CLK_PERIOD;

  logic                         aluclk = 1'b0;
  logic                         rst_n;
  logic                         bdest;
  logic                         xfetch_n;
  logic [wrf_pkg::ADDR_W-1:0]   laa;
  logic [wrf_pkg::ADDR_W-1:0]   lba;
  alu_pkg::alu_op_e             alu_op;
  logic [DATA_W-1:0]            lit;
  logic [DATA_W-1:0]            a;
  logic [DATA_W-1:0]            b;
  logic [DATA_W-1:0]            rb;
  logic [DATA_W-1:0]            pr;
  logic [DATA_W-1:0]            br;
  logic [DATA_W-1:0]            xr;
  logic [wrf_pkg::NUM_REGS-1:0] ea;
  logic                         wpn;
  logic                         wr3;
  logic                         wr7;
  int                           error_count;
  int                           check_count;

  always #(CLK_PERIOD / 2) aluclk = ~aluclk;

  cga_datapath #(.DATA_W(DATA_W)) UUT (
    .aluclk(aluclk), .rst_n(rst_n), .bdest(bdest), .xfetch_n(xfetch_n),
    .laa(laa), .lba(lba), .alu_op(alu_op), .lit(lit),
    .a(a), .b(b), .rb(rb), .pr(pr), .br(br), .xr(xr),
    .ea(ea), .wpn(wpn), .wr3(wr3), .wr7(wr7)
  );

  cga_datapath_checker #(.DATA_W(DATA_W)) chk (
    .aluclk(aluclk), .rst_n(rst_n), .bdest(bdest), .xfetch_n(xfetch_n),
    .laa(laa), .lba(lba), .alu_op(alu_op), .lit(lit),
    .a(a), .b(b), .rb(rb), .pr(pr), .br(br), .xr(xr),
    .ea(ea), .wpn(wpn), .wr3(wr3), .wr7(wr7),
    .error_count(error_count), .check_count(check_count)
  );

  // Distinct per address, odd multiplier keeps it a bijection
  function automatic logic [DATA_W-1:0] literal_for(input int addr);
    return DATA_W'(32'h9e37 * (addr + 1));
  endfunction

  // One microstep, applied just after the rising edge
  task automatic drive_step(input logic dest, input logic fetch_n,
                            input logic [wrf_pkg::ADDR_W-1:0] src_a,
                            input logic [wrf_pkg::ADDR_W-1:0] src_b,
                            input alu_pkg::alu_op_e op, input logic [DATA_W-1:0] value);
    @(posedge aluclk);
    bdest    <= dest;
    xfetch_n <= fetch_n;
    laa      <= src_a;
    lba      <= src_b;
    alu_op   <= op;
    lit      <= value;
  endtask

  initial begin
    void'($urandom(32'h08ac_73aa));
    rst_n    = 1'b0;
    bdest    = 1'b0;
    xfetch_n = 1'b1;
    laa      = '0;
    lba      = '0;
    alu_op   = alu_pkg::OP_PASS_A;
    lit      = '0;
    repeat (RESET_CYCLES) @(posedge aluclk);
    rst_n <= 1'b1;
    // Every register reads zero after reset
    for (int i = 0; i < wrf_pkg::NUM_REGS; i++) begin
      drive_step(1'b0, 1'b1, 4'(i), 4'(15 - i), alu_pkg::OP_PASS_A, '0);
    end
    // Literal into each register, Z included
    for (int i = 0; i < wrf_pkg::NUM_REGS; i++) begin
      drive_step(1'b1, 1'b1, 4'(i), 4'(i), alu_pkg::OP_LIT, literal_for(i));
    end
    // Read back on both ports
    for (int i = 0; i < wrf_pkg::NUM_REGS; i++) begin
      drive_step(1'b0, 1'b1, 4'(i), 4'(15 - i), alu_pkg::OP_PASS_B, '0);
    end
    // Random microsteps, fetch active about a quarter of the time
    repeat (RAND_STEPS) begin
      drive_step(1'($urandom_range(0, 1)), $urandom_range(0, 3) != 0,
                 4'($urandom_range(0, 15)), 4'($urandom_range(0, 15)),
                 alu_pkg::alu_op_e'($urandom_range(0, 7)), DATA_W'($urandom));
    end
    // P close to the top so the advance wraps
    drive_step(1'b1, 1'b1, wrf_pkg::REG_P, wrf_pkg::REG_P, alu_pkg::OP_LIT, 16'hfffd);
    repeat (FETCH_STEPS) begin
      drive_step(1'b0, 1'b0, wrf_pkg::REG_P, wrf_pkg::REG_P, alu_pkg::OP_PASS_A, '0);
    end
    // Destination write against fetch in one step
    drive_step(1'b1, 1'b0, wrf_pkg::REG_P, wrf_pkg::REG_P, alu_pkg::OP_LIT, 16'h1234);
    drive_step(1'b0, 1'b1, wrf_pkg::REG_P, wrf_pkg::REG_P, alu_pkg::OP_PASS_A, '0);
    // Last step compared at the next edge
    @(posedge aluclk);
    @(negedge aluclk);
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/alu_pkg.sv
// ALU opcode encoding, referenced by scoped name from the datapath and the testbench
`default_nettype none

package alu_pkg;

  // Opcode field width
  localparam int OP_W = 3;

  // ALU operations
  // One opcode per microstep, all eight codes in use
  typedef enum logic [OP_W-1:0] {
    // Pass the A read port through
    OP_PASS_A = 3'd0,
    // Pass the B read port through
    OP_PASS_B = 3'd1,
    // Sum modulo 2**DATA_W
    OP_ADD    = 3'd2,
    // Difference, two's complement
    OP_SUB    = 3'd3,
    // Bitwise logic
    OP_AND    = 3'd4,
    OP_OR     = 3'd5,
    OP_XOR    = 3'd6,
    // Microcode literal
    OP_LIT    = 3'd7
  } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/cga_alu.sv
// Combinational ALU forming the write-back value and the next P value for the register file
`default_nettype none

module cga_alu #(
  parameter int DATA_W = 16
) (
  // Read port A
  input  wire [DATA_W-1:0] a,
  // Read port B
  input  wire [DATA_W-1:0] b,
  // Current program counter
  input  wire [DATA_W-1:0] pr,
  // Literal from the microword
  input  wire [DATA_W-1:0] lit,
  input  wire alu_pkg::alu_op_e alu_op,
  // Write-back data
  output logic [DATA_W-1:0] rb,
  // Next location, P plus one
  output logic [DATA_W-1:0] nlca
);

  // Ones complement of B for the subtract path
  logic [DATA_W-1:0] b_inv;

  assign b_inv = ~b;

  // Result select
  always_comb begin
    case (alu_op)
      alu_pkg::OP_PASS_A: begin
        rb = a;
      end
      alu_pkg::OP_PASS_B: begin
        rb = b;
      end
      alu_pkg::OP_ADD: begin
        // Carry out dropped
        rb = a + b;
      end
      alu_pkg::OP_SUB: begin
        // A plus inverted B plus carry in
        rb = a + b_inv + DATA_W'(1);
      end
      alu_pkg::OP_AND: begin
        rb = a & b;
      end
      alu_pkg::OP_OR: begin
        rb = a | b;
      end
      alu_pkg::OP_XOR: begin
        rb = a ^ b;
      end
      alu_pkg::OP_LIT: begin
        rb = lit;
      end
      default: begin
        rb = '0;
      end
    endcase
  end

  // Fetch increment
  // Wraps to zero at the top of the address space
  assign nlca = pr + DATA_W'(1);

endmodule

`default_nettype wire

//--- verilog/cga_datapath.sv
// Datapath top joining the ALU and the register file, driven each cycle by an external microsequencer
`default_nettype none

module cga_datapath #(
  parameter int DATA_W = 16
) (
  input  wire                          aluclk,
  // Synchronous reset, active low
  input  wire                          rst_n,
  // Write rb into the register at lba
  input  wire                          bdest,
  // Advance P this step, active low
  input  wire                          xfetch_n,
  // Source A address
  input  wire [wrf_pkg::ADDR_W-1:0]    laa,
  // Source B and destination address
  input  wire [wrf_pkg::ADDR_W-1:0]    lba,
  input  wire alu_pkg::alu_op_e        alu_op,
  // Literal for OP_LIT
  input  wire [DATA_W-1:0]             lit,
  // Read data
  output logic [DATA_W-1:0]            a,
  output logic [DATA_W-1:0]            b,
  // ALU result, also the write-back value
  output logic [DATA_W-1:0]            rb,
  // P, B and X straight from the registers
  output logic [DATA_W-1:0]            pr,
  output logic [DATA_W-1:0]            br,
  output logic [DATA_W-1:0]            xr,
  // Source one-hot enable
  output logic [wrf_pkg::NUM_REGS-1:0] ea,
  // Write strobes for P, B and X
  output logic                         wpn,
  output logic                         wr3,
  output logic                         wr7
);

  // Next P from the ALU incrementer
  logic [DATA_W-1:0] nlca;

  // Result and next location
  cga_alu #(
    .DATA_W(DATA_W)
  ) alu (
    .a     (a),
    .b     (b),
    .pr    (pr),
    .lit   (lit),
    .alu_op(alu_op),
    .rb    (rb),
    .nlca  (nlca)
  );

  // Registers, decode and strobes
  cga_wrf #(
    .DATA_W(DATA_W)
  ) wrf (
    .aluclk  (aluclk),
    .rst_n   (rst_n),
    .bdest   (bdest),
    .xfetch_n(xfetch_n),
    .laa     (laa),
    .lba     (lba),
    .rb      (rb),
    .nlca    (nlca),
    .ea      (ea),
    .a       (a),
    .b       (b),
    .pr      (pr),
    .br      (br),
    .xr      (xr),
    .wpn     (wpn),
    .wr3     (wr3),
    .wr7     (wr7)
  );

endmodule

`default_nettype wire

//--- verilog/cga_wrf.sv
// Register file wrapper with source and destination decode and write strobes around the register block
`default_nettype none

module cga_wrf #(
  parameter int DATA_W = 16
) (
  input  wire                          aluclk,
  input  wire                          rst_n,
  // Destination write level for this microstep
  input  wire                          bdest,
  // Fetch advance of P, active low
  input  wire                          xfetch_n,
  // Source and destination register addresses
  input  wire [wrf_pkg::ADDR_W-1:0]    laa,
  input  wire [wrf_pkg::ADDR_W-1:0]    lba,
  // Write-back data
  input  wire [DATA_W-1:0]             rb,
  // Incremented P
  input  wire [DATA_W-1:0]             nlca,
  // One-hot source enable
  output logic [wrf_pkg::NUM_REGS-1:0] ea,
  output logic [DATA_W-1:0]            a,
  output logic [DATA_W-1:0]            b,
  // Direct register outputs
  output logic [DATA_W-1:0]            pr,
  output logic [DATA_W-1:0]            br,
  output logic [DATA_W-1:0]            xr,
  // P strobe, active low
  output logic                         wpn,
  // B and X strobes, active high
  output logic                         wr3,
  output logic                         wr7
);

  // One-hot destination enable
  logic [wrf_pkg::NUM_REGS-1:0] eb;
  // Gated write strobes, one per register
  logic [wrf_pkg::NUM_REGS-1:0] wr;

  // 4 to 16 one-hot decode
  // Stands in for the paired 3 to 8 decoders of the gate array
  function automatic logic [wrf_pkg::NUM_REGS-1:0] dec_1h(
    input logic [wrf_pkg::ADDR_W-1:0] addr
  );
    logic [wrf_pkg::NUM_REGS-1:0] sel;
    sel = '0;
    sel[addr] = 1'b1;
    return sel;
  endfunction

  assign ea = dec_1h(laa);
  assign eb = dec_1h(lba);

  // No strobe without bdest
  assign wr = eb & {wrf_pkg::NUM_REGS{bdest}};

  // Strobes used outside the slice
  assign wpn = ~wr[wrf_pkg::REG_P];
  assign wr3 = wr[wrf_pkg::REG_B];
  assign wr7 = wr[wrf_pkg::REG_X];

  cga_wrf_rblock #(
    .DATA_W(DATA_W)
  ) rblock (
    .aluclk  (aluclk),
    .rst_n   (rst_n),
    .xfetch_n(xfetch_n),
    .ea      (ea),
    .eb      (eb),
    .wr      (wr),
    .rb      (rb),
    .nlca    (nlca),
    .a       (a),
    .b       (b),
    .pr      (pr),
    .br      (br),
    .xr      (xr)
  );

endmodule

`default_nettype wire

//--- verilog/cga_wrf_rblock.sv
// Sixteen-entry register block with one-hot read ports and the P fetch advance, used inside cga_wrf
`default_nettype none

module cga_wrf_rblock #(
  parameter int DATA_W = 16
) (
  input  wire                          aluclk,
  input  wire                          rst_n,
  // Low loads nlca into P when P is not written
  input  wire                          xfetch_n,
  // One-hot read selects
  input  wire [wrf_pkg::NUM_REGS-1:0]  ea,
  input  wire [wrf_pkg::NUM_REGS-1:0]  eb,
  // Write strobes, already gated by bdest
  input  wire [wrf_pkg::NUM_REGS-1:0]  wr,
  input  wire [DATA_W-1:0]             rb,
  input  wire [DATA_W-1:0]             nlca,
  output logic [DATA_W-1:0]            a,
  output logic [DATA_W-1:0]            b,
  output logic [DATA_W-1:0]            pr,
  output logic [DATA_W-1:0]            br,
  output logic [DATA_W-1:0]            xr
);

  // Storage for D through R7
  // Z has no storage, so its strobe and enables go nowhere
  logic [DATA_W-1:0] regs [1:wrf_pkg::NUM_REGS-1];

  // Register update
  always_ff @(posedge aluclk) begin
    if (!rst_n) begin
      for (int i = 1; i < wrf_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Destination writes from the ALU
      for (int i = 1; i < wrf_pkg::NUM_REGS; i++) begin
        if (wr[i]) begin
          regs[i] <= rb;
        end
      end
      // Fetch advance
      // A destination write to P in the same step takes priority
      if (!xfetch_n && !wr[wrf_pkg::REG_P]) begin
        regs[wrf_pkg::REG_P] <= nlca;
      end
    end
  end

  // Read ports as AND-OR select on the one-hot enables
  // Z contributes nothing, so it reads as zero
  always_comb begin
    a = '0;
    b = '0;
    for (int i = 1; i < wrf_pkg::NUM_REGS; i++) begin
      a = a | ({DATA_W{ea[i]}} & regs[i]);
      b = b | ({DATA_W{eb[i]}} & regs[i]);
    end
  end

  // Direct taps
  assign pr = regs[wrf_pkg::REG_P];
  assign br = regs[wrf_pkg::REG_B];
  // X register, index base for memory ops
  assign xr = regs[wrf_pkg::REG_X];

endmodule

`default_nettype wire

//--- verilog/wrf_pkg.sv
// Register-file constants and register names, referenced by scoped name from RTL and testbench
`default_nettype none

package wrf_pkg;

  // Register address width
  // Four bits select one of sixteen registers
  localparam int ADDR_W = 4;

  // Number of registers in the file
  localparam int NUM_REGS = 16;

  // Register names by address
  // Z always reads as zero
  // P is the program counter, advanced by fetch
  // B and X also leave the slice directly
  // STS is plain storage in this slice, no flag logic
  // R1 to R7 are internal scratch registers
  typedef enum logic [ADDR_W-1:0] {
    REG_Z   = 4'd0,
    REG_D   = 4'd1,
    REG_P   = 4'd2,
    REG_B   = 4'd3,
    REG_L   = 4'd4,
    REG_A   = 4'd5,
    REG_T   = 4'd6,
    REG_X   = 4'd7,
    REG_STS = 4'd8,
    // Internal registers
    REG_R1  = 4'd9,
    REG_R2  = 4'd10,
    REG_R3  = 4'd11,
    REG_R4  = 4'd12,
    REG_R5  = 4'd13,
    REG_R6  = 4'd14,
    REG_R7  = 4'd15
  } reg_e;

endpackage

`default_nettype wire
